// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// ----------------------------------------
	// wishbone classic, single transfers
	// ----------------------------------------

	// data bus width in bits
	localparam int wb_data_width = 32;

	// byte address, full 32-bit space seen by the masters
	localparam int wb_addr_width = 32;

	// one select per data byte
	localparam int wb_sel_width = wb_data_width / 8;

endpackage

`default_nettype wire

// ==== common/memory_pkg.sv ====
`default_nettype none

package memory_pkg;

	import bus_pkg::*;

	// ----------------------------------------
	// global memory geometry
	// ----------------------------------------

	// one bank per byte lane of the bus
	localparam int gm_lanes = wb_sel_width;
	localparam int gm_lane_width = wb_data_width / gm_lanes;

	// 8192 words per bank, 32 KiB in total
	localparam int gm_word_addr_width = 13;
	localparam int gm_words = 1 << gm_word_addr_width;
	localparam int gm_offset_width = $clog2(gm_lanes);

	// address bits above the window, zero for the global memory
	localparam int gm_tag_width = wb_addr_width - gm_word_addr_width - gm_offset_width;
	localparam logic [gm_tag_width-1:0] gm_window_tag = '0;

	// the isolator looks at the tag, the controller at word and byte
	typedef union packed {
		logic [wb_addr_width-1:0] raw;
		struct packed {
			logic [gm_tag_width-1:0] tag;
			logic [gm_word_addr_width+gm_offset_width-1:0] offset;
		} window;
		struct packed {
			logic [gm_tag_width-1:0] upper;
			logic [gm_word_addr_width-1:0] index;
			logic [gm_offset_width-1:0] lane;
		} word;
	} gm_address_t;

endpackage

`default_nettype wire

// ==== source/wb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
	import bus_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// host master
	input  logic host_cyc,
	input  logic host_stb,
	input  logic host_we,
	input  logic [wb_sel_width-1:0] host_sel,
	input  logic [wb_addr_width-1:0] host_adr,
	input  logic [wb_data_width-1:0] host_dat_w,
	output logic [wb_data_width-1:0] host_dat_r,
	output logic host_ack,
	output logic host_err,

	// core master
	input  logic core_cyc,
	input  logic core_stb,
	input  logic core_we,
	input  logic [wb_sel_width-1:0] core_sel,
	input  logic [wb_addr_width-1:0] core_adr,
	input  logic [wb_data_width-1:0] core_dat_w,
	output logic [wb_data_width-1:0] core_dat_r,
	output logic core_ack,
	output logic core_err,

	// merged bus towards the isolator
	output logic arb_cyc,
	output logic arb_stb,
	output logic arb_we,
	output logic [wb_sel_width-1:0] arb_sel,
	output logic [wb_addr_width-1:0] arb_adr,
	output logic [wb_data_width-1:0] arb_dat_w,
	input  logic [wb_data_width-1:0] arb_dat_r,
	input  logic arb_ack,
	input  logic arb_err
);

	// grant[0] host, grant[1] core, zero when the bus is idle
	logic [1:0] grant;
	logic last_core;
	logic pick_core;

	// on a tie the port that was not served last wins
	assign pick_core = core_cyc & (~host_cyc | ~last_core);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			grant <= 2'b00;
			last_core <= 1'b0;
		end
		else if (grant == 2'b00)
		begin
			if (host_cyc | core_cyc)
			begin
				grant <= pick_core ? 2'b10 : 2'b01;
				last_core <= pick_core;
			end
		end
		// owner dropped cyc, release the bus
		else if ((grant[0] & ~host_cyc) | (grant[1] & ~core_cyc))
			grant <= 2'b00;
	end

	// ----------------------------------------
	// request path
	// ----------------------------------------
	assign arb_cyc = (grant[0] & host_cyc) | (grant[1] & core_cyc);
	assign arb_stb = (grant[0] & host_stb) | (grant[1] & core_stb);
	assign arb_we = grant[1] ? core_we : host_we;
	assign arb_sel = grant[1] ? core_sel : host_sel;
	assign arb_adr = grant[1] ? core_adr : host_adr;
	assign arb_dat_w = grant[1] ? core_dat_w : host_dat_w;

	// ----------------------------------------
	// response path, only the owner sees it
	// ----------------------------------------
	assign host_ack = grant[0] & arb_ack;
	assign host_err = grant[0] & arb_err;
	assign host_dat_r = grant[0] ? arb_dat_r : '0;
	assign core_ack = grant[1] & arb_ack;
	assign core_err = grant[1] & arb_err;
	assign core_dat_r = grant[1] ? arb_dat_r : '0;

endmodule

`default_nettype wire

// ==== source/address_isolator.sv ====
`timescale 1ns/10ps
`default_nettype none

module address_isolator
	import bus_pkg::*, memory_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// slave side, from the arbiter
	input  logic arb_cyc,
	input  logic arb_stb,
	input  logic arb_we,
	input  logic [wb_sel_width-1:0] arb_sel,
	input  logic [wb_addr_width-1:0] arb_adr,
	input  logic [wb_data_width-1:0] arb_dat_w,
	output logic [wb_data_width-1:0] arb_dat_r,
	output logic arb_ack,
	output logic arb_err,

	// master side, towards the memory controller
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [wb_sel_width-1:0] mem_sel,
	output logic [wb_addr_width-1:0] mem_adr,
	output logic [wb_data_width-1:0] mem_dat_w,
	input  logic [wb_data_width-1:0] mem_dat_r,
	input  logic mem_ack
);

	gm_address_t address;
	logic in_window;
	logic err_q;

	assign address.raw = arb_adr;
	assign in_window = (address.window.tag == gm_window_tag);

	// in-window cycles go straight through
	assign mem_cyc = arb_cyc & in_window;
	assign mem_stb = arb_stb & in_window;
	assign mem_we = arb_we;
	assign mem_sel = arb_sel;
	assign mem_adr = arb_adr;
	assign mem_dat_w = arb_dat_w;

	// out-of-window cycles get a single err pulse, never a memory access
	always_ff @(posedge clk)
	begin
		if (reset)
			err_q <= 1'b0;
		else
			err_q <= arb_cyc & arb_stb & ~in_window & ~err_q;
	end

	assign arb_err = err_q;
	assign arb_ack = mem_ack;
	assign arb_dat_r = mem_dat_r;

endmodule

`default_nettype wire

// ==== global_memory/byte_lane_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module byte_lane_ram
	import memory_pkg::*;
(
	input  logic clk,
	input  logic [gm_word_addr_width-1:0] addr,
	input  logic [gm_lane_width-1:0] wdata,
	input  logic we,
	output logic [gm_lane_width-1:0] rdata
);

	logic [gm_lane_width-1:0] mem [gm_words];

	// read returns the old contents on a write to the same word
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== global_memory/sram_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_controller
	import bus_pkg::*, memory_pkg::*;
(
	input  logic clk,
	input  logic reset,

	// wishbone slave
	input  logic mem_cyc,
	input  logic mem_stb,
	input  logic mem_we,
	input  logic [wb_sel_width-1:0] mem_sel,
	input  logic [wb_addr_width-1:0] mem_adr,
	input  logic [wb_data_width-1:0] mem_dat_w,
	output logic [wb_data_width-1:0] mem_dat_r,
	output logic mem_ack,

	// byte-lane banks
	output logic [gm_word_addr_width-1:0] lane_addr,
	output logic [gm_lanes-1:0][gm_lane_width-1:0] lane_wdata,
	output logic [gm_lanes-1:0] lane_we,
	input  logic [gm_lanes-1:0][gm_lane_width-1:0] lane_rdata
);

	gm_address_t address;
	logic accept;
	logic busy;

	assign address.raw = mem_adr;

	// all banks share the word index, the byte offset is covered by sel
	assign lane_addr = address.word.index;

	// no new request while the previous ack is on the bus
	assign accept = mem_cyc & mem_stb & ~busy;

	// ----------------------------------------
	// lane split and gather
	// ----------------------------------------
	always_comb
	begin
		for (int i = 0; i < gm_lanes; i++)
		begin
			lane_wdata[i] = mem_dat_w[i*gm_lane_width +: gm_lane_width];
			lane_we[i] = accept & mem_we & mem_sel[i];
			mem_dat_r[i*gm_lane_width +: gm_lane_width] = lane_rdata[i];
		end
	end

	// banks register the read on the accept edge, so data lines up with ack
	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else
			busy <= accept;
	end

	assign mem_ack = busy;

endmodule

`default_nettype wire

// ==== source/gm_subsystem_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gm_subsystem_top
	import bus_pkg::*, memory_pkg::*;
(
	input  logic clk,
	input  logic reset,

	input  logic host_cyc,
	input  logic host_stb,
	input  logic host_we,
	input  logic [wb_sel_width-1:0] host_sel,
	input  logic [wb_addr_width-1:0] host_adr,
	input  logic [wb_data_width-1:0] host_dat_w,
	output logic [wb_data_width-1:0] host_dat_r,
	output logic host_ack,
	output logic host_err,

	input  logic core_cyc,
	input  logic core_stb,
	input  logic core_we,
	input  logic [wb_sel_width-1:0] core_sel,
	input  logic [wb_addr_width-1:0] core_adr,
	input  logic [wb_data_width-1:0] core_dat_w,
	output logic [wb_data_width-1:0] core_dat_r,
	output logic core_ack,
	output logic core_err
);

	logic arb_cyc;
	logic arb_stb;
	logic arb_we;
	logic [wb_sel_width-1:0] arb_sel;
	logic [wb_addr_width-1:0] arb_adr;
	logic [wb_data_width-1:0] arb_dat_w;
	logic [wb_data_width-1:0] arb_dat_r;
	logic arb_ack;
	logic arb_err;

	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic [wb_sel_width-1:0] mem_sel;
	logic [wb_addr_width-1:0] mem_adr;
	logic [wb_data_width-1:0] mem_dat_w;
	logic [wb_data_width-1:0] mem_dat_r;
	logic mem_ack;

	logic [gm_word_addr_width-1:0] lane_addr;
	logic [gm_lanes-1:0][gm_lane_width-1:0] lane_wdata;
	logic [gm_lanes-1:0][gm_lane_width-1:0] lane_rdata;
	logic [gm_lanes-1:0] lane_we;

	wb_arbiter wb_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_sel(host_sel),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.host_err(host_err),
		.core_cyc(core_cyc),
		.core_stb(core_stb),
		.core_we(core_we),
		.core_sel(core_sel),
		.core_adr(core_adr),
		.core_dat_w(core_dat_w),
		.core_dat_r(core_dat_r),
		.core_ack(core_ack),
		.core_err(core_err),
		.arb_cyc(arb_cyc),
		.arb_stb(arb_stb),
		.arb_we(arb_we),
		.arb_sel(arb_sel),
		.arb_adr(arb_adr),
		.arb_dat_w(arb_dat_w),
		.arb_dat_r(arb_dat_r),
		.arb_ack(arb_ack),
		.arb_err(arb_err)
	);

	address_isolator address_isolator_i
	(
		.clk(clk),
		.reset(reset),
		.arb_cyc(arb_cyc),
		.arb_stb(arb_stb),
		.arb_we(arb_we),
		.arb_sel(arb_sel),
		.arb_adr(arb_adr),
		.arb_dat_w(arb_dat_w),
		.arb_dat_r(arb_dat_r),
		.arb_ack(arb_ack),
		.arb_err(arb_err),
		.mem_cyc(mem_cyc),
		.mem_stb(mem_stb),
		.mem_we(mem_we),
		.mem_sel(mem_sel),
		.mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w),
		.mem_dat_r(mem_dat_r),
		.mem_ack(mem_ack)
	);

	sram_controller sram_controller_i
	(
		.clk(clk),
		.reset(reset),
		.mem_cyc(mem_cyc),
		.mem_stb(mem_stb),
		.mem_we(mem_we),
		.mem_sel(mem_sel),
		.mem_adr(mem_adr),
		.mem_dat_w(mem_dat_w),
		.mem_dat_r(mem_dat_r),
		.mem_ack(mem_ack),
		.lane_addr(lane_addr),
		.lane_wdata(lane_wdata),
		.lane_we(lane_we),
		.lane_rdata(lane_rdata)
	);

	// one bank per byte lane
	for (genvar i = 0; i < gm_lanes; i++)
	begin : gen_lane
		byte_lane_ram byte_lane_ram_i
		(
			.clk(clk),
			.addr(lane_addr),
			.wdata(lane_wdata[i]),
			.we(lane_we[i]),
			.rdata(lane_rdata[i])
		);
	end

endmodule

`default_nettype wire

// ==== verification/gm_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gm_subsystem_tb
	import bus_pkg::*;
();

	// ----------------------------------------
	// stimulus layout, one transfer per line
	// ----------------------------------------
	localparam int num_fields = 8;
	localparam int num_lines = 18;
	localparam int col_test = 0;
	localparam int col_port = 1;
	localparam int col_op = 2;
	localparam int col_adr = 3;
	localparam int col_sel = 4;
	localparam int col_wdata = 5;
	localparam int col_status = 6;
	localparam int col_rdata = 7;
	localparam int timeout_cycles = 40;

	logic clk = 1'b0;
	logic reset = 1'b1;

	logic host_cyc = 1'b0;
	logic host_stb = 1'b0;
	logic host_we = 1'b0;
	logic [wb_sel_width-1:0] host_sel = '0;
	logic [wb_addr_width-1:0] host_adr = '0;
	logic [wb_data_width-1:0] host_dat_w = '0;
	logic [wb_data_width-1:0] host_dat_r;
	logic host_ack;
	logic host_err;

	logic core_cyc = 1'b0;
	logic core_stb = 1'b0;
	logic core_we = 1'b0;
	logic [wb_sel_width-1:0] core_sel = '0;
	logic [wb_addr_width-1:0] core_adr = '0;
	logic [wb_data_width-1:0] core_dat_w = '0;
	logic [wb_data_width-1:0] core_dat_r;
	logic core_ack;
	logic core_err;

	logic [31:0] stim [num_lines*num_fields];
	int check_count = 0;
	int error_count = 0;
	int timeout_count = 0;
	int line_idx;

	gm_subsystem_top gm_subsystem_top_i
	(
		.clk(clk),
		.reset(reset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_sel(host_sel),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.host_err(host_err),
		.core_cyc(core_cyc),
		.core_stb(core_stb),
		.core_we(core_we),
		.core_sel(core_sel),
		.core_adr(core_adr),
		.core_dat_w(core_dat_w),
		.core_dat_r(core_dat_r),
		.core_ack(core_ack),
		.core_err(core_err)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] field_of(input int line, input int col);
		return stim[line*num_fields+col];
	endfunction

	function automatic string test_name(input logic [31:0] id);
		case (id)
			32'd2: return "full_word_write_read";
			32'd3: return "partial_select_write";
			32'd4: return "core_write_host_read";
			32'd5: return "out_of_window_access";
			32'd6: return "simultaneous_ports";
			default: return "unknown";
		endcase
	endfunction

	// a port with cyc low must never see a response meant for the other one
	always @(negedge clk)
	begin
		if (!reset)
		begin
			check_count++;
			assert (host_cyc || (!host_ack && !host_err))
			else
			begin
				$display("ERROR idle_port_response: expected host 00, actual %b%b",
					host_ack, host_err);
				error_count++;
			end
			assert (core_cyc || (!core_ack && !core_err))
			else
			begin
				$display("ERROR idle_port_response: expected core 00, actual %b%b",
					core_ack, core_err);
				error_count++;
			end
		end
	end

	// no response may show up while both ports are idle
	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			check_count++;
			assert ({host_ack, host_err, core_ack, core_err} == 4'b0000)
			else
			begin
				$display("ERROR idle_after_reset: expected 0000, actual %b",
					{host_ack, host_err, core_ack, core_err});
				error_count++;
			end
		end
	endtask

	task automatic check_response(input int line, input logic ack, input logic err,
		input logic [31:0] data);
		logic [31:0] exp_status;
		logic [31:0] got_status;
		string name;
		name = test_name(field_of(line, col_test));
		exp_status = field_of(line, col_status);
		// 0 ack, 1 err, 2 both at once
		got_status = (ack & err) ? 32'd2 : (err ? 32'd1 : 32'd0);
		check_count++;
		assert (got_status == exp_status)
		else
		begin
			$display("ERROR %s line %0d status: expected %0d, actual %0d",
				name, line, exp_status, got_status);
			error_count++;
		end
		if (field_of(line, col_op) == 32'd0 && exp_status == 32'd0)
		begin
			check_count++;
			assert (data == field_of(line, col_rdata))
			else
			begin
				$display("ERROR %s line %0d data: expected %h, actual %h",
					name, line, field_of(line, col_rdata), data);
				error_count++;
			end
		end
	endtask

	// ----------------------------------------
	// one wishbone classic transfer per port
	// ----------------------------------------
	task automatic host_transfer(input int line);
		logic [31:0] op_word;
		logic [31:0] sel_word;
		logic done;
		logic ack_seen;
		logic err_seen;
		logic [31:0] data_seen;
		int waited;
		op_word = field_of(line, col_op);
		sel_word = field_of(line, col_sel);
		done = 1'b0;
		ack_seen = 1'b0;
		err_seen = 1'b0;
		data_seen = '0;
		waited = 0;
		@(posedge clk);
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we <= op_word[0];
		host_sel <= sel_word[wb_sel_width-1:0];
		host_adr <= field_of(line, col_adr);
		host_dat_w <= field_of(line, col_wdata);
		while (!done && waited < timeout_cycles)
		begin
			@(negedge clk);
			if (host_ack || host_err)
			begin
				done = 1'b1;
				ack_seen = host_ack;
				err_seen = host_err;
				data_seen = host_dat_r;
			end
			else
				waited++;
		end
		if (done)
			check_response(line, ack_seen, err_seen, data_seen);
		else
		begin
			$display("timeout: host transfer on line %0d got neither ack nor err", line);
			timeout_count++;
		end
		@(posedge clk);
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		// a second response would mean a duplicated transfer
		@(negedge clk);
		check_count++;
		assert (!host_ack && !host_err)
		else
		begin
			$display("ERROR %s line %0d host repeat: expected 00, actual %b%b",
				test_name(field_of(line, col_test)), line, host_ack, host_err);
			error_count++;
		end
	endtask

	task automatic core_transfer(input int line);
		logic [31:0] op_word;
		logic [31:0] sel_word;
		logic done;
		logic ack_seen;
		logic err_seen;
		logic [31:0] data_seen;
		int waited;
		op_word = field_of(line, col_op);
		sel_word = field_of(line, col_sel);
		done = 1'b0;
		ack_seen = 1'b0;
		err_seen = 1'b0;
		data_seen = '0;
		waited = 0;
		@(posedge clk);
		core_cyc <= 1'b1;
		core_stb <= 1'b1;
		core_we <= op_word[0];
		core_sel <= sel_word[wb_sel_width-1:0];
		core_adr <= field_of(line, col_adr);
		core_dat_w <= field_of(line, col_wdata);
		while (!done && waited < timeout_cycles)
		begin
			@(negedge clk);
			if (core_ack || core_err)
			begin
				done = 1'b1;
				ack_seen = core_ack;
				err_seen = core_err;
				data_seen = core_dat_r;
			end
			else
				waited++;
		end
		if (done)
			check_response(line, ack_seen, err_seen, data_seen);
		else
		begin
			$display("timeout: core transfer on line %0d got neither ack nor err", line);
			timeout_count++;
		end
		@(posedge clk);
		core_cyc <= 1'b0;
		core_stb <= 1'b0;
		@(negedge clk);
		check_count++;
		assert (!core_ack && !core_err)
		else
		begin
			$display("ERROR %s line %0d core repeat: expected 00, actual %b%b",
				test_name(field_of(line, col_test)), line, core_ack, core_err);
			error_count++;
		end
	endtask

	initial
	begin
		$readmemh("verification/gm_stimulus.txt", stim);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		check_idle(4);

		// port 2 starts the host line and the next core line together
		line_idx = 0;
		while (line_idx < num_lines)
		begin
			if (field_of(line_idx, col_port) == 32'd2)
			begin
				fork
					host_transfer(line_idx);
					core_transfer(line_idx + 1);
				join
				line_idx += 2;
			end
			else if (field_of(line_idx, col_port) == 32'd1)
			begin
				core_transfer(line_idx);
				line_idx++;
			end
			else
			begin
				host_transfer(line_idx);
				line_idx++;
			end
		end

		$display("checks: %0d, errors: %0d, timeouts: %0d",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/gm_stimulus.txt ====
// test port op address sel wdata status rdata, all hex
// port 0 host, 1 core, 2 host paired with the core line below; op 1 write; status 0 ack, 1 err
2 0 1 00000010 f 12345678 0 00000000
2 0 0 00000010 f 00000000 0 12345678
3 0 1 00000020 f deadbeef 0 00000000
3 0 1 00000020 5 11223344 0 00000000
3 0 0 00000020 f 00000000 0 de22be44
3 0 1 00000024 f cafef00d 0 00000000
3 0 1 00000024 8 99000000 0 00000000
3 0 0 00000024 f 00000000 0 99fef00d
4 1 1 00000100 f 0badc0de 0 00000000
4 0 0 00000100 f 00000000 0 0badc0de
5 0 1 00000000 f 87654321 0 00000000
5 0 1 00008000 f ffffffff 1 00000000
5 1 0 10000000 f 00000000 1 00000000
5 0 0 00000000 f 00000000 0 87654321
6 2 0 00000010 f 00000000 0 12345678
6 1 0 00000100 f 00000000 0 0badc0de
6 2 0 00000020 f 00000000 0 de22be44
6 1 0 00000024 f 00000000 0 99fef00d

// ==== list.f ====
common/bus_pkg.sv
common/memory_pkg.sv
source/wb_arbiter.sv
source/address_isolator.sv
global_memory/byte_lane_ram.sv
global_memory/sram_controller.sv
source/gm_subsystem_top.sv
verification/gm_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module gm_subsystem_tb -f list.f -o gm_sim \
	&& ./obj_dir/gm_sim > sim.log 2>&1 \
	|| { echo "build or run error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
